//--- common/vbank_config.svh
`ifndef VBANK_CONFIG_SVH
`define VBANK_CONFIG_SVH

// Sizes of the 1R1W virtual-bank memory.
// A logical address is {vbnk, row}; a physical address is {pbnk, row}.

`define VB_WIDTH      16   // Data bits per word

`define VB_NUM_VBNK   4    // Virtual banks
`define VB_BIT_VBNK   2

`define VB_NUM_PBNK   5    // Physical banks, one spare
`define VB_BIT_PBNK   3

`define VB_NUM_ROWS   16   // Rows per bank
`define VB_BIT_ROWS   4

`define VB_INIT_FREE  4    // Spare bank of each row after init

`endif

//--- common/vbank_pkg.sv
`include "vbank_config.svh"

package vbank_pkg;

  typedef logic [`VB_WIDTH-1:0]    word_t;
  typedef logic [`VB_BIT_VBNK-1:0] vbnk_t;
  typedef logic [`VB_BIT_PBNK-1:0] pbnk_t;
  typedef logic [`VB_BIT_ROWS-1:0] row_t;

  // Logical address, virtual bank in the upper bits
  typedef struct packed {
    vbnk_t vbnk;
    row_t  row;
  } vaddr_t;

  // Physical address returned with each read
  typedef struct packed {
    pbnk_t pbnk;
    row_t  row;
  } padr_t;

  // One row of the map table, indexed by virtual bank
  typedef pbnk_t [`VB_NUM_VBNK-1:0] map_row_t;

endpackage

//--- files.f
+incdir+common
common/vbank_pkg.sv
rtl/sp_bank.sv
rtl/rd_select.sv
vbank_map/vbank_map.sv
rtl/vbank_1r1w_top.sv
testbench/vbank_assert.sv
testbench/tb_vbank_1r1w.sv

//--- rtl/rd_select.sv
`include "vbank_config.svh"

module rd_select (
  input  logic             clk,
  input  logic             reset,
  input  logic             bank_read,
  input  vbank_pkg::pbnk_t rd_pbnk,
  input  vbank_pkg::row_t  rd_row,
  input  vbank_pkg::word_t bank_dout [`VB_NUM_PBNK],
  output logic             rd_vld,
  output vbank_pkg::word_t rd_dout,
  output vbank_pkg::padr_t rd_padr
);

  import vbank_pkg::*;

  pbnk_t sel_pbnk;   // Bank serving the read in flight
  row_t  sel_row;

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_vld <= 1'b0;
    end else begin
      rd_vld <= bank_read;
    end
  end

  always_ff @(posedge clk) begin
    if (bank_read) begin
      sel_pbnk <= rd_pbnk;
      sel_row  <= rd_row;
    end
  end

  // Bank output mux, valid in the return cycle
  always_comb begin
    rd_dout = '0;
    for (int b = 0; b < `VB_NUM_PBNK; b++) begin
      if (sel_pbnk == pbnk_t'(b)) begin
        rd_dout = bank_dout[b];
      end
    end
  end

  assign rd_padr = {sel_pbnk, sel_row};

endmodule

//--- rtl/sp_bank.sv
`include "vbank_config.svh"

module sp_bank (
  input  logic             clk,
  input  logic             read,
  input  logic             write,
  input  vbank_pkg::row_t  addr,
  input  vbank_pkg::word_t din,
  output vbank_pkg::word_t dout
);

  import vbank_pkg::*;

  word_t mem [`VB_NUM_ROWS];

  // Single port, one access per cycle
  always_ff @(posedge clk) begin
    if (write) begin
      mem[addr] <= din;
    end else if (read) begin
      dout <= mem[addr];   // Registered read
    end
  end

endmodule

//--- rtl/vbank_1r1w_top.sv
`include "vbank_config.svh"

module vbank_1r1w_top (
  input  logic              clk,
  input  logic              reset,
  input  logic              read,
  input  logic              write,
  input  vbank_pkg::vaddr_t rd_addr,
  input  vbank_pkg::vaddr_t wr_addr,
  input  vbank_pkg::word_t  din,
  output logic              ready,
  output logic              rd_vld,
  output vbank_pkg::word_t  rd_dout,
  output vbank_pkg::padr_t  rd_padr
);

  import vbank_pkg::*;

  logic  bank_read;
  logic  bank_write;
  pbnk_t rd_pbnk;
  pbnk_t wr_pbnk;
  row_t  rd_row;
  row_t  wr_row;
  word_t wr_data;
  word_t bank_dout [`VB_NUM_PBNK];

  vbank_map u_vbank_map (
    .clk        (clk),
    .reset      (reset),
    .read       (read),
    .write      (write),
    .rd_addr    (rd_addr),
    .wr_addr    (wr_addr),
    .din        (din),
    .ready      (ready),
    .bank_read  (bank_read),
    .bank_write (bank_write),
    .rd_pbnk    (rd_pbnk),
    .wr_pbnk    (wr_pbnk),
    .rd_row     (rd_row),
    .wr_row     (wr_row),
    .wr_data    (wr_data)
  );

  // Per-bank decode. The map never sends the read and the write to one bank,
  // so each bank sees at most one of the two enables.
  genvar b;
  generate
    for (b = 0; b < `VB_NUM_PBNK; b++) begin : g_bank
      logic rd_en;
      logic wr_en;
      row_t row;

      assign rd_en = bank_read && (rd_pbnk == pbnk_t'(b));
      assign wr_en = bank_write && (wr_pbnk == pbnk_t'(b));
      assign row   = wr_en ? wr_row : rd_row;   // Write row when this bank takes the write

      sp_bank u_sp_bank (
        .clk   (clk),
        .read  (rd_en),
        .write (wr_en),
        .addr  (row),
        .din   (wr_data),
        .dout  (bank_dout[b])
      );
    end
  endgenerate

  rd_select u_rd_select (
    .clk       (clk),
    .reset     (reset),
    .bank_read (bank_read),
    .rd_pbnk   (rd_pbnk),
    .rd_row    (rd_row),
    .bank_dout (bank_dout),
    .rd_vld    (rd_vld),
    .rd_dout   (rd_dout),
    .rd_padr   (rd_padr)
  );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log
rm -f "$BUILD_LOG" "$SIM_LOG"

verilator --binary --timing --assert --top-module tb_vbank_1r1w \
  -f files.f -o tb_vbank_1r1w > "$BUILD_LOG" 2>&1 \
  || { cat "$BUILD_LOG"; echo "Verilator build failed"; exit 1; }

# A simulator abort, for example on an assertion, counts as a failure
./obj_dir/tb_vbank_1r1w > "$SIM_LOG" 2>&1 \
  || echo "sim failed" >> "$SIM_LOG"

cat "$SIM_LOG"

grep -q "sim failed" "$SIM_LOG" && { echo "Result: FAIL"; exit 1; }
grep -q "sim passed" "$SIM_LOG" || { echo "Result: no pass line in log"; exit 1; }
echo "Result: PASS"
exit 0

//--- testbench/tb_vbank_1r1w.sv
`include "vbank_config.svh"

module tb_vbank_1r1w;

  timeunit 1ns;
  timeprecision 1ps;

  import vbank_pkg::*;

  localparam int num_addr = `VB_NUM_VBNK * `VB_NUM_ROWS;

  typedef struct packed {
    logic   rd;
    vaddr_t ra;
    logic   wr;
    vaddr_t wa;
    word_t  din;
    logic   chk;        // Compare rd_padr with exp_padr
    padr_t  exp_padr;
  } stim_t;

  logic   clk;
  logic   reset;
  logic   read;
  logic   write;
  vaddr_t rd_addr;
  vaddr_t wr_addr;
  word_t  din;
  logic   ready;
  logic   rd_vld;
  word_t  rd_dout;
  padr_t  rd_padr;

  stim_t  tbl [$];
  int     wlist [$];      // Addresses written by the table so far
  bit     gen_written [num_addr];

  // Reference model of the logical memory and the bank tables
  word_t  mem_model [num_addr];
  bit     written_model [num_addr];
  pbnk_t  map_model [`VB_NUM_ROWS][`VB_NUM_VBNK];
  pbnk_t  free_model [`VB_NUM_ROWS];

  // Expected return of the read in flight
  logic   pend_rd;
  logic   pend_known;
  word_t  pend_data;
  padr_t  pend_padr;
  logic   pend_tbl_chk;
  padr_t  pend_tbl_padr;

  int     err_count;
  int     check_count;
  int     cycle_cnt;
  int     max_cycles;
  int     cycles;
  bit     ready_seen;

  vbank_1r1w_top u_vbank_1r1w_top (
    .clk     (clk),
    .reset   (reset),
    .read    (read),
    .write   (write),
    .rd_addr (rd_addr),
    .wr_addr (wr_addr),
    .din     (din),
    .ready   (ready),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout),
    .rd_padr (rd_padr)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic vaddr_t make_vaddr(int v, int r);
    vaddr_t a;
    a.vbnk = vbnk_t'(v);
    a.row  = row_t'(r);
    return a;
  endfunction

  function automatic padr_t make_padr(int b, int r);
    padr_t p;
    p.pbnk = pbnk_t'(b);
    p.row  = row_t'(r);
    return p;
  endfunction

  function automatic void push_stim(logic rd, vaddr_t ra, logic wr, vaddr_t wa,
                                    word_t wdata, logic chk, padr_t exp_padr);
    stim_t s;
    s = {rd, ra, wr, wa, wdata, chk, exp_padr};
    tbl.push_back(s);
    if (wr && !gen_written[int'(wa)]) begin
      gen_written[int'(wa)] = 1'b1;
      wlist.push_back(int'(wa));
    end
  endfunction

  task automatic build_table();
    vaddr_t ra;
    vaddr_t wa;
    padr_t  none;
    none = make_padr(0, 0);
    push_stim(0, make_vaddr(0, 0), 1, make_vaddr(1, 2), 16'h1111, 0, none);
    push_stim(0, make_vaddr(0, 0), 1, make_vaddr(1, 5), 16'h2222, 0, none);
    push_stim(0, make_vaddr(0, 0), 1, make_vaddr(3, 5), 16'h3333, 0, none);
    push_stim(1, make_vaddr(1, 2), 0, make_vaddr(0, 0), 16'h0000, 1, make_padr(1, 2));
    push_stim(1, make_vaddr(1, 5), 0, make_vaddr(0, 0), 16'h0000, 1, make_padr(1, 5));
    // Conflict moves the write to the spare bank of row 5
    push_stim(1, make_vaddr(1, 2), 1, make_vaddr(1, 5), 16'h4444, 1, make_padr(1, 2));
    push_stim(1, make_vaddr(1, 5), 0, make_vaddr(0, 0), 16'h0000, 1, make_padr(4, 5));
    // Same address read and written returns the old word
    push_stim(1, make_vaddr(3, 5), 1, make_vaddr(3, 5), 16'h5555, 1, make_padr(3, 5));
    push_stim(1, make_vaddr(3, 5), 0, make_vaddr(0, 0), 16'h0000, 1, make_padr(1, 5));
    push_stim(0, make_vaddr(0, 0), 1, make_vaddr(2, 0), 16'h6666, 0, none);
    push_stim(1, make_vaddr(2, 0), 0, make_vaddr(0, 0), 16'h0000, 1, make_padr(2, 0));
    push_stim(0, make_vaddr(0, 0), 0, make_vaddr(0, 0), 16'h0000, 0, none);
    push_stim(1, make_vaddr(1, 5), 0, make_vaddr(0, 0), 16'h0000, 1, make_padr(4, 5));
    for (int n = 0; n < 200; n++) begin
      ra = vaddr_t'(6'(wlist[$urandom_range(wlist.size() - 1, 0)]));
      wa = vaddr_t'(6'($urandom_range(num_addr - 1, 0)));
      push_stim(1, ra, 1, wa, word_t'($urandom), 0, none);
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    check_count++;
    if (act_val !== exp_val) begin
      err_count++;
      $display("ERROR at %0t: %s expected %0h, got %0h", $time, name, exp_val, act_val);
    end
  endtask

  task automatic check_return();
    check_value("rd_vld", 32'(pend_rd), 32'(rd_vld));
    if (pend_rd) begin
      if (pend_known) begin
        check_value("rd_dout", 32'(pend_data), 32'(rd_dout));
      end
      check_value("rd_padr", 32'(pend_padr), 32'(rd_padr));
      if (pend_tbl_chk) begin
        check_value("rd_padr (table)", 32'(pend_tbl_padr), 32'(rd_padr));
      end
    end
  endtask

  // Drives one row and steps the model the way the memory should
  task automatic drive_row(input stim_t s);
    pbnk_t rp;
    pbnk_t home;
    read    = s.rd;
    rd_addr = s.ra;
    write   = s.wr;
    wr_addr = s.wa;
    din     = s.din;
    pend_rd       = s.rd;
    pend_tbl_chk  = s.rd && s.chk;
    pend_tbl_padr = s.exp_padr;
    rp = '1;
    if (s.rd) begin
      rp         = map_model[s.ra.row][s.ra.vbnk];
      pend_padr  = {rp, s.ra.row};
      pend_data  = mem_model[int'(s.ra)];   // Old word on a same-cycle write
      pend_known = written_model[int'(s.ra)];
    end
    if (s.wr) begin
      home = map_model[s.wa.row][s.wa.vbnk];
      if (s.rd && home == rp) begin
        map_model[s.wa.row][s.wa.vbnk] = free_model[s.wa.row];
        free_model[s.wa.row] = home;
      end
      mem_model[int'(s.wa)] = s.din;
      written_model[int'(s.wa)] = 1'b1;
    end
  endtask

  task automatic drive_idle();
    read    = 1'b0;
    write   = 1'b0;
    rd_addr = '0;
    wr_addr = '0;
    din     = '0;
  endtask

  initial begin
    max_cycles = 0;
    cycle_cnt  = 0;
    wait (max_cycles > 0);
    while (cycle_cnt < max_cycles) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, the test did not finish", cycle_cnt);
    $display("sim failed");
    $finish;
  end

  initial begin
    reset = 1'b1;
    drive_idle();
    err_count   = 0;
    check_count = 0;
    pend_rd     = 1'b0;
    void'($urandom(32'h927));
    for (int r = 0; r < `VB_NUM_ROWS; r++) begin
      for (int v = 0; v < `VB_NUM_VBNK; v++) begin
        map_model[r][v] = pbnk_t'(v);
      end
      free_model[r] = pbnk_t'(`VB_NUM_VBNK);   // Spare bank after init
    end
    build_table();
    max_cycles = tbl.size() + 16 + 50;

    repeat (8) @(posedge clk);
    #1;
    check_value("ready", 32'(0), 32'(ready));
    check_value("rd_vld", 32'(0), 32'(rd_vld));
    #1;
    reset = 1'b0;

    // Strobes during the sweep must be ignored
    cycles     = 0;
    ready_seen = 1'b0;
    while (!ready_seen) begin
      @(posedge clk);
      #1;
      cycles++;
      check_value("rd_vld", 32'(0), 32'(rd_vld));
      if (ready === 1'b1) begin
        ready_seen = 1'b1;
      end else begin
        #1;
        read    = 1'b1;
        rd_addr = make_vaddr(0, cycles);
        write   = 1'b1;
        wr_addr = make_vaddr(3, cycles);
        din     = 16'hbad0 + word_t'(cycles);
      end
    end
    check_value("ready delay", 32'(16), 32'(cycles));
    #1;
    drive_idle();

    foreach (tbl[i]) begin
      @(posedge clk);
      #1;
      check_return();
      #1;
      drive_row(tbl[i]);
    end
    @(posedge clk);
    #1;
    check_return();
    #1;
    drive_idle();
    pend_rd = 1'b0;
    @(posedge clk);
    #1;
    check_return();

    $display("Checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- testbench/vbank_assert.sv
`include "vbank_config.svh"

module vbank_assert (
  input logic             clk,
  input logic             reset,
  input logic             ready,
  input logic             bank_read,
  input logic             bank_write,
  input vbank_pkg::pbnk_t rd_pbnk,
  input vbank_pkg::pbnk_t wr_pbnk
);

  timeunit 1ns;
  timeprecision 1ps;

  import vbank_pkg::*;

  // Read and write never share a single-port bank
  a_split_banks: assert property (@(posedge clk) disable iff (reset)
    (bank_read && bank_write) |-> (rd_pbnk != wr_pbnk))
    else $error("read and write steered to the same physical bank");

  // Banks stay idle until the sweep has covered every row
  a_sweep_length: assert property (@(posedge clk) disable iff (reset)
    $rose(ready) |-> ($past(reset, `VB_NUM_ROWS + 1) && !$past(reset, `VB_NUM_ROWS)))
    else $error("ready rose before the init sweep covered every row");

  a_wr_bank_range: assert property (@(posedge clk) disable iff (reset)
    bank_write |-> (wr_pbnk < pbnk_t'(`VB_NUM_PBNK)))
    else $error("write bank index outside the physical banks");

endmodule

bind vbank_map vbank_assert u_vbank_assert (
  .clk        (clk),
  .reset      (reset),
  .ready      (ready),
  .bank_read  (bank_read),
  .bank_write (bank_write),
  .rd_pbnk    (rd_pbnk),
  .wr_pbnk    (wr_pbnk)
);

//--- vbank_map/vbank_map.sv
`include "vbank_config.svh"

module vbank_map (
  input  logic              clk,
  input  logic              reset,
  input  logic              read,
  input  logic              write,
  input  vbank_pkg::vaddr_t rd_addr,
  input  vbank_pkg::vaddr_t wr_addr,
  input  vbank_pkg::word_t  din,
  output logic              ready,
  output logic              bank_read,
  output logic              bank_write,
  output vbank_pkg::pbnk_t  rd_pbnk,
  output vbank_pkg::pbnk_t  wr_pbnk,
  output vbank_pkg::row_t   rd_row,
  output vbank_pkg::row_t   wr_row,
  output vbank_pkg::word_t  wr_data
);

  import vbank_pkg::*;

  map_row_t map_tbl  [`VB_NUM_ROWS];   // Virtual to physical bank, per row
  pbnk_t    free_tbl [`VB_NUM_ROWS];   // Unused physical bank, per row

  row_t     init_row;
  logic     init_last;
  map_row_t ident_row;
  vbnk_t    rd_vbnk;
  vbnk_t    wr_vbnk;
  pbnk_t    wr_home;
  pbnk_t    wr_free;
  logic     conflict;

  assign rd_vbnk = rd_addr.vbnk;
  assign wr_vbnk = wr_addr.vbnk;
  assign rd_row  = rd_addr.row;
  assign wr_row  = wr_addr.row;

  // Identity mapping loaded by the sweep
  always_comb begin
    for (int v = 0; v < `VB_NUM_VBNK; v++) begin
      ident_row[v] = pbnk_t'(v);
    end
  end

  // Init sweep, one row per cycle
  assign init_last = (init_row == row_t'(`VB_NUM_ROWS - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      init_row <= '0;
      ready    <= 1'b0;
    end else if (!ready) begin
      init_row <= init_row + 1'b1;
      if (init_last) begin
        ready <= 1'b1;   // Last row written this cycle
      end
    end
  end

  // Steering
  assign rd_pbnk    = map_tbl[rd_row][rd_vbnk];
  assign wr_home    = map_tbl[wr_row][wr_vbnk];
  assign wr_free    = free_tbl[wr_row];
  assign bank_read  = ready && read;
  assign bank_write = ready && write;

  // Write would hit the bank the read is using
  assign conflict = bank_read && bank_write && (wr_home == rd_pbnk);

  assign wr_pbnk = conflict ? wr_free : wr_home;
  assign wr_data = din;

  // Table update. On a conflict the row's word moves to the spare bank and
  // the bank it left becomes the new spare.
  always_ff @(posedge clk) begin
    if (!reset && !ready) begin
      map_tbl[init_row]  <= ident_row;
      free_tbl[init_row] <= pbnk_t'(`VB_INIT_FREE);
    end else if (conflict) begin
      map_tbl[wr_row][wr_vbnk] <= wr_free;
      free_tbl[wr_row]         <= wr_home;
    end
  end

endmodule
